/* aluUnit.sv */
// Arithmetic and logic unit
// Executes the decoded ALU operation on two 32-bit operands. Shifts act
// on operand B, with the amount taken from the instruction shamt field
// or from operand A. Also flags a zero result for branch decisions.

`default_nettype none

module aluUnit (
	input  wire mipsPkg::aluOpE aluOp,
	input  wire logic           shamtSel,
	input  wire logic [4:0]     shamt,
	input  wire logic [31:0]    operandA,
	input  wire logic [31:0]    operandB,
	output logic [31:0]         result,
	output logic                zero
);

	logic [4:0] shiftAmount;

	// Register-sourced amount keeps the path ready for variable shifts
	assign shiftAmount = shamtSel ? shamt : operandA[4:0];

	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: begin
				result = operandA + operandB;
			end
			mipsPkg::aluSub: begin
				result = operandA - operandB; // Also drives the beq and bne compare
			end
			mipsPkg::aluAnd: begin
				result = operandA & operandB;
			end
			mipsPkg::aluOr: begin
				result = operandA | operandB;
			end
			mipsPkg::aluSlt: begin
				result = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
			end
			mipsPkg::aluSll: begin
				result = operandB << shiftAmount;
			end
			mipsPkg::aluSrl: begin
				result = operandB >> shiftAmount; // Logical, zeros shift in
			end
			mipsPkg::aluLui: begin
				result = {operandB[15:0], 16'h0000};
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* controlUnit.sv */
// Main decoder
// Maps the opcode, and for R-type the function code, to the full set
// of control signals including the final ALU operation. Opcodes and
// functions outside the supported subset give an all-zero control set
// so the instruction has no effect.

`default_nettype none

module controlUnit (
	input  wire mipsPkg::instrT instr,
	output mipsPkg::ctrlT       ctrl
);

	always_comb begin
		case (instr.op)
			mipsPkg::rType: begin
				case (instr.funct)
					mipsPkg::sllFn:
						ctrl = '{shamtSel: 1'b1, regDst: 1'b1, regWrite: 1'b1,
							aluOp: mipsPkg::aluSll, default: 1'b0};
					mipsPkg::srlFn:
						ctrl = '{shamtSel: 1'b1, regDst: 1'b1, regWrite: 1'b1,
							aluOp: mipsPkg::aluSrl, default: 1'b0};
					mipsPkg::jrFn:
						ctrl = '{regJump: 1'b1, aluOp: mipsPkg::aluAdd, default: 1'b0};
					mipsPkg::addFn:
						ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluAdd,
							default: 1'b0};
					mipsPkg::subFn:
						ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluSub,
							default: 1'b0};
					mipsPkg::andFn:
						ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluAnd,
							default: 1'b0};
					mipsPkg::orFn:
						ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluOr,
							default: 1'b0};
					mipsPkg::sltFn:
						ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluSlt,
							default: 1'b0};
					default:
						ctrl = '0; // Unsupported function acts as a nop
				endcase
			end
			mipsPkg::addiOp:
				ctrl = '{aluSrc: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluAdd, default: 1'b0};
			mipsPkg::oriOp:
				ctrl = '{aluSrc: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluOr, default: 1'b0};
			mipsPkg::luiOp:
				ctrl = '{aluSrc: 1'b1, regWrite: 1'b1, aluOp: mipsPkg::aluLui, default: 1'b0};
			mipsPkg::lwOp:
				ctrl = '{aluSrc: 1'b1, memToReg: 1'b1, regWrite: 1'b1, memRead: 1'b1,
					aluOp: mipsPkg::aluAdd, default: 1'b0};
			mipsPkg::swOp:
				ctrl = '{aluSrc: 1'b1, memWrite: 1'b1, aluOp: mipsPkg::aluAdd, default: 1'b0};
			mipsPkg::jOp:
				ctrl = '{jump: 1'b1, aluOp: mipsPkg::aluAdd, default: 1'b0};
			mipsPkg::jalOp:
				ctrl = '{linkWrite: 1'b1, jump: 1'b1, regWrite: 1'b1,
					aluOp: mipsPkg::aluAdd, default: 1'b0};
			mipsPkg::beqOp:
				ctrl = '{branchEq: 1'b1, aluOp: mipsPkg::aluSub, default: 1'b0};
			mipsPkg::bneOp:
				ctrl = '{branchNe: 1'b1, aluOp: mipsPkg::aluSub, default: 1'b0};
			default:
				ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

/* dataMemory.sv */
// Data memory and trace output
// Word-addressed data memory written on the clock edge and read
// asynchronously. Also forms the writeback and store trace pulses,
// which are high during the cycle whose edge commits the write.

`default_nettype none

module dataMemory (
	input  wire logic        clk,
	input  wire logic        arstN,
	input  wire logic        run,
	input  wire logic        memWrite,
	input  wire logic        memRead,
	input  wire logic        regWrite,
	input  wire logic [31:0] addr,
	input  wire logic [31:0] writeData,
	input  wire logic [4:0]  wbReg,
	input  wire logic [31:0] wbData,
	output logic [31:0]      readData,
	output logic             wbValid,
	output mipsPkg::wbTraceT wbTrace,
	output logic             storeValid,
	output mipsPkg::storeTraceT storeTrace
);

	logic [31:0] dmem [mipsPkg::dmemDepth];
	logic [mipsPkg::dmemAddrW-1:0] wordAddr;

	assign wordAddr = addr[mipsPkg::dmemAddrW+1:2]; // Upper address bits wrap

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::dmemDepth; i++) begin
				dmem[i] <= '0;
			end
		end else if (memWrite && run) begin
			dmem[wordAddr] <= writeData;
		end
	end

	assign readData = memRead ? dmem[wordAddr] : 32'd0;

	assign wbValid = regWrite && run;
	assign wbTrace = '{regNum: wbReg, data: wbData};
	assign storeValid = memWrite && run;
	assign storeTrace = '{wordAddr: wordAddr, data: writeData};

	// Base register plus offset from the program must land on a word boundary
	wordAccess: assert property (@(posedge clk) disable iff (!arstN)
		(run && (memWrite || memRead)) |-> (addr[1:0] == 2'b00));

endmodule

`default_nettype wire

/* instrFetch.sv */
// Instruction fetch
// Holds the program counter and the instruction memory. The memory is
// filled through a load strobe while the core is halted and is read
// asynchronously at the current PC. The next PC is picked from jr,
// jump, taken branch or the sequential address.

`default_nettype none

module instrFetch (
	input  wire logic                          clk,
	input  wire logic                          arstN,
	input  wire logic                          run,
	input  wire logic                          loadEn,
	input  wire logic [mipsPkg::imemAddrW-1:0] loadAddr,
	input  wire mipsPkg::instrT                loadData,
	input  wire mipsPkg::ctrlT                 ctrl,
	input  wire logic                          zero,
	input  wire logic [31:0]                   regTarget,
	output mipsPkg::instrT                     instr,
	output logic [31:0]                        pc,
	output logic [31:0]                        pcPlus4
);

	mipsPkg::instrT imem [mipsPkg::imemDepth];
	logic [31:0] pcNext;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [15:0] imm;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < mipsPkg::imemDepth; i++) begin
				imem[i] <= '0; // Zero words decode as sll $0, a nop
			end
		end else if (loadEn) begin
			imem[loadAddr] <= loadData;
		end
	end

	assign instr = imem[pc[mipsPkg::imemAddrW+1:2]];
	assign imm = instr[15:0];

	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00}; // Stays in the current 256 MB region

	always_comb begin
		if (ctrl.regJump) begin
			pcNext = regTarget;
		end else if (ctrl.jump) begin
			pcNext = jumpTarget;
		end else if ((ctrl.branchEq && zero) || (ctrl.branchNe && !zero)) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (run) begin
			pc <= pcNext; // Low run freezes the PC
		end
	end

	// A jr to a misaligned register value would break word fetch
	pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

	// Program loading happens only while the core is halted
	loadWhileIdle: assert property (@(posedge clk) disable iff (!arstN) !(loadEn && run));

endmodule

`default_nettype wire

/* mipsCore.f */
+incdir+.
mipsPkg.sv
instrFetch.sv
controlUnit.sv
regFile.sv
aluUnit.sv
dataMemory.sv
mipsCore.sv
tbMipsCore.sv

/* mipsCore.sv */
// Single-cycle MIPS subset core
// Connects fetch, decode, register file, ALU and data memory so that
// one instruction completes per clock while run is high. Selects the
// ALU immediate operand, the writeback source and the destination
// register, and exposes writeback and store traces.

`default_nettype none

module mipsCore (
	input  wire logic                          clk,
	input  wire logic                          arstN,
	input  wire logic                          run,
	input  wire logic                          loadEn,
	input  wire logic [mipsPkg::imemAddrW-1:0] loadAddr,
	input  wire mipsPkg::instrT                loadData,
	output logic                               wbValid,
	output mipsPkg::wbTraceT                   wbTrace,
	output logic                               storeValid,
	output mipsPkg::storeTraceT                storeTrace,
	output logic [31:0]                        pc
);

	mipsPkg::instrT instr;
	mipsPkg::ctrlT  ctrl;
	logic [31:0] pcPlus4;
	logic [31:0] readA;
	logic [31:0] readB;
	logic [31:0] immExt;
	logic [31:0] aluB;
	logic [31:0] result;
	logic        zero;
	logic [31:0] loadWord;
	logic [4:0]  writeReg;
	logic [31:0] writeData;
	logic [15:0] imm;

	assign imm = instr[15:0];

	// ori uses a zero-extended immediate, lui ignores the upper half anyway
	assign immExt = (ctrl.aluOp == mipsPkg::aluOr) ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign aluB = ctrl.aluSrc ? immExt : readB;

	assign writeReg = ctrl.linkWrite ? mipsPkg::linkReg : (ctrl.regDst ? instr.rd : instr.rt);
	assign writeData = ctrl.linkWrite ? pcPlus4 : (ctrl.memToReg ? loadWord : result);

	instrFetch uFetch (
		.clk(clk), .arstN(arstN), .run(run),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.ctrl(ctrl), .zero(zero), .regTarget(readA),
		.instr(instr), .pc(pc), .pcPlus4(pcPlus4)
	);

	controlUnit uControl (.instr(instr), .ctrl(ctrl));

	regFile uRegs (
		.clk(clk), .arstN(arstN), .writeEn(ctrl.regWrite && run),
		.writeReg(writeReg), .writeData(writeData),
		.readRegA(instr.rs), .readRegB(instr.rt), .readA(readA), .readB(readB)
	);

	aluUnit uAlu (
		.aluOp(ctrl.aluOp), .shamtSel(ctrl.shamtSel), .shamt(instr.shamt),
		.operandA(readA), .operandB(aluB), .result(result), .zero(zero)
	);

	dataMemory uDmem (
		.clk(clk), .arstN(arstN), .run(run),
		.memWrite(ctrl.memWrite), .memRead(ctrl.memRead), .regWrite(ctrl.regWrite),
		.addr(result), .writeData(readB), .wbReg(writeReg), .wbData(writeData),
		.readData(loadWord), .wbValid(wbValid), .wbTrace(wbTrace),
		.storeValid(storeValid), .storeTrace(storeTrace)
	);

endmodule

`default_nettype wire

/* mipsPkg.sv */
// MIPS subset shared definitions
// Instruction word layout, opcode and function encodings, the decoded
// control set, ALU operations, trace records and memory sizes used by
// every block of the single-cycle core.

`default_nettype none

package mipsPkg;

	localparam int imemDepth = 64;                   // Instruction memory words
	localparam int dmemDepth = 64;                   // Data memory words
	localparam int imemAddrW = $clog2(imemDepth);
	localparam int dmemAddrW = $clog2(dmemDepth);
	localparam logic [4:0] linkReg = 5'd31;          // Return address register for jal

	typedef enum logic [5:0] {
		rType  = 6'h00,
		jOp    = 6'h02,
		jalOp  = 6'h03,
		beqOp  = 6'h04,
		bneOp  = 6'h05,
		addiOp = 6'h08,
		oriOp  = 6'h0d,
		luiOp  = 6'h0f,
		lwOp   = 6'h23,
		swOp   = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		sllFn = 6'h00,
		srlFn = 6'h02,
		jrFn  = 6'h08,
		addFn = 6'h20,
		subFn = 6'h22,
		andFn = 6'h24,
		orFn  = 6'h25,
		sltFn = 6'h2a
	} functE;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluSlt = 4'd4,
		aluSll = 4'd5,
		aluSrl = 4'd6,
		aluLui = 4'd7
	} aluOpE;

	// R-type view of the word, the immediate is bits 15:0 and the jump target bits 25:0
	typedef struct packed {
		opcodeE     op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functE      funct;
	} instrT;

	typedef struct packed {
		logic  linkWrite; // Write PC+4 to register 31
		logic  regJump;   // Next PC from rs (jr)
		logic  jump;
		logic  shamtSel;
		logic  regDst;
		logic  aluSrc;
		logic  memToReg;
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  branchNe;
		logic  branchEq;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic [4:0]  regNum;
		logic [31:0] data;
	} wbTraceT;

	typedef struct packed {
		logic [dmemAddrW-1:0] wordAddr;
		logic [31:0]          data;
	} storeTraceT;

endpackage

`default_nettype wire

/* regFile.sv */
// Register file
// Thirty-two 32-bit registers with two asynchronous read ports and one
// write port committed on the rising clock edge. Register 0 is hard
// wired to zero and ignores writes.

`default_nettype none

module regFile (
	input  wire logic        clk,
	input  wire logic        arstN,
	input  wire logic        writeEn,
	input  wire logic [4:0]  writeReg,
	input  wire logic [31:0] writeData,
	input  wire logic [4:0]  readRegA,
	input  wire logic [4:0]  readRegB,
	output logic [31:0]      readA,
	output logic [31:0]      readB
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeReg != 5'd0)) begin
			regs[writeReg] <= writeData; // $0 writes are traced upstream but dropped here
		end
	end

	assign readA = regs[readRegA];
	assign readB = regs[readRegB];

	// Holds across any sequence of writes, including writes that target $0
	zeroReadA: assert property (@(posedge clk) disable iff (!arstN)
		(readRegA == 5'd0) |-> (readA == 32'd0));
	zeroReadB: assert property (@(posedge clk) disable iff (!arstN)
		(readRegB == 5'd0) |-> (readB == 32'd0));

endmodule

`default_nettype wire

/* tbMipsCoreChecks.svh */
// Compare tasks for the MIPS core testbench
// Writeback and store trace records and the program counter are each
// compared against the expected value taken from the event table.

`ifndef TB_MIPS_CORE_CHECKS_SVH
`define TB_MIPS_CORE_CHECKS_SVH

task automatic checkWb(input mipsPkg::wbTraceT got, input mipsPkg::wbTraceT exp);
	if (got !== exp) begin
		abortTest($sformatf("FAIL at %0t: writeback r%0d = %h, expected r%0d = %h",
			$time, got.regNum, got.data, exp.regNum, exp.data));
	end
endtask

task automatic checkStore(input mipsPkg::storeTraceT got, input mipsPkg::storeTraceT exp);
	if (got !== exp) begin
		abortTest($sformatf("FAIL at %0t: store word %0d = %h, expected word %0d = %h",
			$time, got.wordAddr, got.data, exp.wordAddr, exp.data));
	end
endtask

task automatic comparePc(input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		abortTest($sformatf("FAIL at %0t: pc = %h while halted, expected %h",
			$time, got, exp));
	end
endtask

`endif

/* tbMipsCore.sv */
// Testbench for the single-cycle MIPS core
// Loads a short program through the load port, runs it and compares every
// writeback and store trace with a table of expected events. One entry
// halts the core for a few cycles to check that its state is frozen.

`default_nettype none

module tbMipsCore;

	typedef enum logic [1:0] {evWb, evStore, evPause} eventKindE;

	typedef struct packed {
		eventKindE   kind;
		logic [5:0]  num;   // Register number, or data word address for a store
		logic [31:0] value; // Expected data, or the held pc for a pause
	} eventT;

	localparam int progLen = 23;
	localparam int eventCount = 18;
	localparam int eventTimeout = 50;
	localparam int pauseCycles = 5;

	logic clk;
	logic arstN;
	logic run;
	logic loadEn;
	logic [mipsPkg::imemAddrW-1:0] loadAddr;
	mipsPkg::instrT loadData;
	logic wbValid;
	mipsPkg::wbTraceT wbTrace;
	logic storeValid;
	mipsPkg::storeTraceT storeTrace;
	logic [31:0] pc;

	mipsPkg::instrT progMem [progLen];
	eventT events [eventCount];

	mipsCore uut (
		.clk(clk), .arstN(arstN), .run(run),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.wbValid(wbValid), .wbTrace(wbTrace),
		.storeValid(storeValid), .storeTrace(storeTrace), .pc(pc)
	);

	`include "tbMipsCoreChecks.svh"

	task automatic abortTest(input string line);
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	function automatic mipsPkg::instrT rInstr(input mipsPkg::functE fn,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return mipsPkg::instrT'({mipsPkg::rType, rs, rt, rd, sh, fn});
	endfunction

	function automatic mipsPkg::instrT iInstr(input mipsPkg::opcodeE op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return mipsPkg::instrT'({op, rs, rt, imm});
	endfunction

	function automatic mipsPkg::instrT jInstr(input mipsPkg::opcodeE op, input logic [25:0] target);
		return mipsPkg::instrT'({op, target});
	endfunction

	task automatic buildTables();
		progMem[0] = iInstr(mipsPkg::addiOp, 0, 1, 16'd5);         // addi $1, $0, 5
		progMem[1] = iInstr(mipsPkg::addiOp, 0, 2, 16'hfffd);      // addi $2, $0, -3
		progMem[2] = iInstr(mipsPkg::oriOp, 0, 3, 16'hf0f7);       // ori $3, $0, 0xf0f7
		progMem[3] = iInstr(mipsPkg::luiOp, 0, 4, 16'h1234);       // lui $4, 0x1234
		progMem[4] = iInstr(mipsPkg::addiOp, 0, 0, 16'd7);         // addi $0, $0, 7
		progMem[5] = rInstr(mipsPkg::addFn, 0, 1, 5, 0);           // add $5, $0, $1
		progMem[6] = rInstr(mipsPkg::subFn, 1, 2, 6, 0);           // sub $6, $1, $2
		progMem[7] = rInstr(mipsPkg::andFn, 3, 2, 7, 0);           // and $7, $3, $2
		progMem[8] = rInstr(mipsPkg::orFn, 4, 3, 8, 0);            // or $8, $4, $3
		progMem[9] = rInstr(mipsPkg::sltFn, 2, 1, 9, 0);           // slt $9, $2, $1
		progMem[10] = rInstr(mipsPkg::sllFn, 0, 1, 10, 4);         // sll $10, $1, 4
		progMem[11] = rInstr(mipsPkg::srlFn, 0, 4, 11, 8);         // srl $11, $4, 8
		progMem[12] = iInstr(mipsPkg::swOp, 10, 8, 16'hfff0);      // sw $8, -16($10)
		progMem[13] = iInstr(mipsPkg::lwOp, 0, 12, 16'd64);        // lw $12, 64($0)
		progMem[14] = iInstr(mipsPkg::beqOp, 1, 5, 16'd1);         // beq $1, $5, +1 (taken)
		progMem[15] = iInstr(mipsPkg::addiOp, 0, 13, 16'd99);      // Skipped by the beq
		progMem[16] = iInstr(mipsPkg::bneOp, 1, 5, 16'd1);         // bne $1, $5, +1 (not taken)
		progMem[17] = jInstr(mipsPkg::jalOp, 26'd20);              // jal to word 20
		progMem[18] = jInstr(mipsPkg::jOp, 26'd22);                // j to word 22
		progMem[19] = iInstr(mipsPkg::addiOp, 0, 14, 16'h0066);    // Skipped by the j
		progMem[20] = iInstr(mipsPkg::addiOp, 0, 15, 16'h0055);    // Subroutine body
		progMem[21] = rInstr(mipsPkg::jrFn, 31, 0, 0, 0);          // jr $31
		progMem[22] = rInstr(mipsPkg::addFn, 15, 1, 16, 0);        // add $16, $15, $1
		events[0] = '{evWb, 6'd1, 32'h0000_0005};
		events[1] = '{evWb, 6'd2, 32'hffff_fffd};
		events[2] = '{evWb, 6'd3, 32'h0000_f0f7};                 // Zero-extended immediate
		events[3] = '{evWb, 6'd4, 32'h1234_0000};
		events[4] = '{evWb, 6'd0, 32'h0000_0007};                 // Traced, $0 stays zero
		events[5] = '{evWb, 6'd5, 32'h0000_0005};
		events[6] = '{evPause, 6'd0, 32'h0000_0018};              // pc of word 6 is held
		events[7] = '{evWb, 6'd6, 32'h0000_0008};                 // 5 - (-3)
		events[8] = '{evWb, 6'd7, 32'h0000_f0f5};
		events[9] = '{evWb, 6'd8, 32'h1234_f0f7};
		events[10] = '{evWb, 6'd9, 32'h0000_0001};                // Signed -3 < 5
		events[11] = '{evWb, 6'd10, 32'h0000_0050};
		events[12] = '{evWb, 6'd11, 32'h0012_3400};
		events[13] = '{evStore, 6'd16, 32'h1234_f0f7};            // Byte address 0x40
		events[14] = '{evWb, 6'd12, 32'h1234_f0f7};
		events[15] = '{evWb, 6'd31, 32'h0000_0048};               // Return address of the jal
		events[16] = '{evWb, 6'd15, 32'h0000_0055};
		events[17] = '{evWb, 6'd16, 32'h0000_005a};
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	initial begin
		int waited;
		arstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		buildTables();
		repeat (4) @(negedge clk);
		arstN = 1'b1;
		for (int i = 0; i < progLen; i++) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = i[mipsPkg::imemAddrW-1:0];
			loadData = progMem[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		run = 1'b1;
		for (int e = 0; e < eventCount; e++) begin
			if (events[e].kind == evPause) begin
				run = 1'b0;
				repeat (pauseCycles) begin
					#1; // Middle of the low phase, the falling-edge drive has settled
					if (wbValid || storeValid) begin
						abortTest("A trace pulse appeared while run was low");
					end
					comparePc(pc, events[e].value);
					@(negedge clk);
				end
				run = 1'b1;
			end else begin
				#1;
				waited = 0;
				while (!(wbValid || storeValid)) begin
					if (waited == eventTimeout) begin
						abortTest($sformatf("Timed out at %0t waiting for trace event %0d",
							$time, e));
					end
					@(negedge clk);
					#1;
					waited++;
				end
				if (events[e].kind == evWb) begin
					if (!wbValid) begin
						abortTest($sformatf("FAIL at %0t: event %0d is a store, expected a writeback",
							$time, e));
					end
					checkWb(wbTrace, mipsPkg::wbTraceT'{regNum: events[e].num[4:0],
						data: events[e].value});
				end else begin
					if (!storeValid) begin
						abortTest($sformatf("FAIL at %0t: event %0d is a writeback, expected a store",
							$time, e));
					end
					checkStore(storeTrace, mipsPkg::storeTraceT'{wordAddr: events[e].num,
						data: events[e].value});
				end
				@(negedge clk);
			end
		end
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
